//--- list.f
+incdir+test
source/hl_cmd_pkg.sv
source/hl_sense_pkg.sv
source/hl_cmd_if.sv
source/ms_timebase.sv
source/led_stretch.sv
source/fan_thermal_ctrl.sv
source/tx_keying.sv
source/status_frame.sv
source/hl_ctrl_top.sv
test/hl_ctrl_tb.sv

//--- test/hl_ctrl_tests.svh
`ifndef HL_CTRL_TESTS_SVH
`define HL_CTRL_TESTS_SVH

// Packed as inttr, exttr, envpa, envop, envbias and rfsw_sel from the top bit
function automatic logic [5:0] pa_outputs(input logic tx, input logic vna,
                                          input logic pa_en, input logic tr_dis);
  logic [5:0] v;
  v[5] = tx & !vna & (pa_en | !tr_dis);
  v[4] = tx;
  v[3] = tx & !vna & pa_en;
  v[2] = tx;
  v[1] = tx & !vna & pa_en;
  v[0] = !vna & pa_en;
  return v;
endfunction

task automatic send_cmd(input logic [5:0] addr, input logic [31:0] data, input logic ptt);
  cmd_rqst = 1'b1;
  cmd_addr = addr;
  cmd_data = data;
  cmd_ptt  = ptt;
  @(negedge clk);
  cmd_rqst = 1'b0;
endtask

// Keys must be stable for a cycle before the strobe
task automatic strobe_and_check(input logic exp_clip);
  logic [39:0] exp;
  exp         = '0;
  exp[36:35]  = model_slot;
  exp[34]     = cw_keydown;
  exp[32]     = cw_keydown | ext_ptt;
  case (model_slot)
    2'd0: begin
      exp[24]  = exp_clip;
      exp[7:0] = VERSION_MAJOR;
    end
    2'd1: begin
      exp[27:16] = temperature;
      exp[11:0]  = fwd_pwr;
    end
    2'd2: begin
      exp[27:16] = rev_pwr;
      exp[11:0]  = bias_current;
    end
    default: ;
  endcase
  resp_rqst = 1'b1;
  @(negedge clk);
  resp_rqst = 1'b0;
  check_value("status frame", resp, exp);
  model_slot = model_slot + 2'd1;
endtask

task automatic test_reset_state();
  int errs;
  errs = err_cnt;
  check_value("tx_on after reset", tx_on, 1'b0);
  check_value("PA outputs after reset",
              {pa_inttr, pa_exttr, pwr_envpa, pwr_envop, pwr_envbias, rfsw_sel}, 6'd0);
  check_value("resp after reset", resp, 40'd0);
  check_value("fan_pwm after reset", fan_pwm, 1'b0);
  check_value("LED pins after reset", {led_run_n, led_tx_n, led_rxgood_n, led_clip_n}, 4'hf);
  finish_test("reset", errs);
endtask

task automatic test_keying();
  int errs;
  int src;
  errs = err_cnt;
  run  = 1'b1;
  for (src = 0; src < 3; src++) begin
    cw_keydown = (src == 0);
    ext_ptt    = (src == 1);
    tx_hang    = (src == 2);
    @(negedge clk);
    check_value("tx_on from local key source", tx_on, 1'b1);
    {cw_keydown, ext_ptt, tx_hang} = 3'b000;
    @(negedge clk);
    check_value("tx_on after key release", tx_on, 1'b0);
  end
  // Command PTT is captured first and keys a cycle later
  send_cmd(6'h00, 32'h0, 1'b1);
  check_value("tx_on while PTT is captured", tx_on, 1'b0);
  @(negedge clk);
  check_value("tx_on from command PTT", tx_on, 1'b1);
  send_cmd(6'h00, 32'h0, 1'b0);
  @(negedge clk);
  check_value("tx_on after command PTT clear", tx_on, 1'b0);
  cw_keydown    = 1'b1;
  ext_txinhibit = 1'b1;
  @(negedge clk);
  check_value("tx_on under inhibit", tx_on, 1'b0);
  ext_txinhibit = 1'b0;
  @(negedge clk);
  check_value("tx_on after inhibit drops", tx_on, 1'b1);
  run = 1'b0;
  @(negedge clk);
  check_value("tx_on with run low", tx_on, 1'b0);
  run        = 1'b1;
  cw_keydown = 1'b0;
  @(negedge clk);
  finish_test("keying", errs);
endtask

task automatic test_mode_cmd();
  int          errs;
  logic [31:0] data;
  logic [5:0]  exp_pa;
  errs = err_cnt;
  run  = 1'b1;
  repeat (6) begin
    data = xorshift32();
    send_cmd(hl_cmd_pkg::CMD_ADDR_MODE, data, 1'b0);
    check_value("PA outputs key up",
                {pa_inttr, pa_exttr, pwr_envpa, pwr_envop, pwr_envbias, rfsw_sel},
                pa_outputs(1'b0, data[23], data[19], data[18]));
    cw_keydown = 1'b1;
    @(negedge clk);
    exp_pa = pa_outputs(1'b1, data[23], data[19], data[18]);
    check_value("PA outputs keyed",
                {pa_inttr, pa_exttr, pwr_envpa, pwr_envop, pwr_envbias, rfsw_sel}, exp_pa);
    // Another address must not touch the mode bits
    send_cmd(6'h0a, ~data, 1'b0);
    check_value("PA outputs after other address",
                {pa_inttr, pa_exttr, pwr_envpa, pwr_envop, pwr_envbias, rfsw_sel}, exp_pa);
    cw_keydown = 1'b0;
    @(negedge clk);
  end
  finish_test("mode command", errs);
endtask

// Settle, then count PWM high cycles over one 16-cycle period
task automatic fan_step(input logic [11:0] temp, input int exp_high, input logic exp_tx);
  int highs;
  int i;
  temperature = temp;
  repeat (2) @(negedge clk);
  highs = 0;
  for (i = 0; i < 16; i++) begin
    highs += fan_pwm;
    @(negedge clk);
  end
  check_value("fan PWM high cycles", highs, exp_high);
  check_value("tx_on under thermal control", tx_on, exp_tx);
endtask

task automatic test_fan();
  int errs;
  errs       = err_cnt;
  run        = 1'b1;
  cw_keydown = 1'b1;
  fan_step(12'h100, 0, 1'b1);
  fan_step(hl_sense_pkg::TEMP_35C + 12'd1, 8, 1'b1);
  fan_step(hl_sense_pkg::TEMP_40C + 12'd1, 12, 1'b1);
  fan_step(hl_sense_pkg::TEMP_45C + 12'd1, 16, 1'b1);
  fan_step(hl_sense_pkg::TEMP_40C, 16, 1'b1);
  fan_step(hl_sense_pkg::TEMP_55C + 12'd1, 16, 1'b0);
  fan_step(hl_sense_pkg::TEMP_50C, 16, 1'b0);
  fan_step(hl_sense_pkg::TEMP_50C - 12'd1, 16, 1'b1);
  fan_step(hl_sense_pkg::TEMP_40C - 12'd1, 12, 1'b1);
  fan_step(hl_sense_pkg::TEMP_35C - 12'd1, 8, 1'b1);
  fan_step(hl_sense_pkg::TEMP_30C - 12'd1, 0, 1'b1);
  temperature = 12'h100;
  cw_keydown  = 1'b0;
  @(negedge clk);
  finish_test("fan", errs);
endtask

task automatic test_status_frame();
  int          errs;
  logic [31:0] r;
  errs = err_cnt;
  repeat (4) begin
    r = xorshift32();
    // Kept below every fan threshold
    temperature = {3'b000, r[8:0]};
    fwd_pwr     = r[31:20];
    r = xorshift32();
    rev_pwr      = r[11:0];
    bias_current = r[27:16];
    cw_keydown   = r[30];
    ext_ptt      = r[31];
    @(negedge clk);
    strobe_and_check(1'b0);
  end
  cw_keydown = 1'b0;
  ext_ptt    = 1'b0;
  @(negedge clk);
  finish_test("status frame", errs);
endtask

task automatic test_clip();
  int errs;
  int i;
  int clip_cycles [4];
  errs        = err_cnt;
  clip_cycles = '{2, 3, 5, 0};
  check_value("clip LED idle", led_clip_n, 1'b1);
  for (i = 0; i < 4; i++) begin
    // Strobing round to slot 0 clears the count as well
    while (model_slot != 2'd0) strobe_and_check(1'b0);
    rxclip = 1'b1;
    repeat (clip_cycles[i]) @(negedge clk);
    rxclip = 1'b0;
    if (clip_cycles[i] > 0) check_value("clip LED after rxclip", led_clip_n, 1'b0);
    @(negedge clk);
    strobe_and_check(clip_cycles[i] >= 3);
  end
  finish_test("clip", errs);
endtask

task automatic test_leds();
  int   errs;
  int   i;
  int   lit;
  logic seen_lo;
  logic seen_hi;
  errs       = err_cnt;
  run        = 1'b1;
  cw_keydown = 1'b1;
  @(negedge clk);
  check_value("run LED with run high", led_run_n, 1'b0);
  check_value("TX LED while keyed", {tx_on, led_tx_n}, 2'b10);
  cw_keydown = 1'b0;
  @(negedge clk);
  check_value("TX LED after key up", {tx_on, led_tx_n}, 2'b01);
  run = 1'b0;
  @(negedge clk);
  check_value("LEDs with run low and link down", {led_run_n, led_tx_n}, 2'b11);
  ethup   = 1'b1;
  seen_lo = 1'b0;
  seen_hi = 1'b0;
  i       = 0;
  while (!(seen_lo && seen_hi) && i < 2 * BLINK_CYC + 8) begin
    @(negedge clk);
    seen_lo = seen_lo | !led_run_n;
    seen_hi = seen_hi | led_run_n;
    i++;
  end
  if (!(seen_lo && seen_hi)) report_timeout("run LED never blinked with the link up");
  run   = 1'b1;
  ethup = 1'b0;
  check_value("rxgood LED idle", led_rxgood_n, 1'b1);
  rxgoodlvl = 1'b1;
  @(negedge clk);
  rxgoodlvl = 1'b0;
  check_value("rxgood LED after trigger", led_rxgood_n, 1'b0);
  lit = 0;
  while (!led_rxgood_n && lit <= 3 * TICK_CYC) begin
    @(negedge clk);
    lit++;
  end
  if (!led_rxgood_n) begin
    report_timeout("rxgood LED still lit after three stretch ticks");
  end else begin
    assert (lit >= 2 * TICK_CYC) else begin
      $display("ERROR at %0t: rxgood LED lit %0d cycles, expected at least %0d",
               $time, lit, 2 * TICK_CYC);
      err_cnt++;
    end
  end
  finish_test("LEDs", errs);
endtask

`endif

//--- test/hl_ctrl_tb.sv
`timescale 1ns/100ps
`default_nettype none

module hl_ctrl_tb;

  localparam int         TICKS_PER_MS  = 4;
  localparam int         FAN_PWM_W     = 4;
  localparam logic [7:0] VERSION_MAJOR = 8'h3c;
  // clk cycles between LED stretch ticks and between blink toggles
  localparam int TICK_CYC  = TICKS_PER_MS << hl_sense_pkg::STRETCH_MS_LOG2;
  localparam int BLINK_CYC = TICKS_PER_MS << hl_sense_pkg::BLINK_MS_LOG2;

  logic        clk;
  logic        slow_adc_rst;
  logic        cmd_rqst;
  logic [5:0]  cmd_addr;
  logic [31:0] cmd_data;
  logic        cmd_ptt;
  logic        run;
  logic        ethup;
  logic        tx_hang;
  logic        cw_keydown;
  logic        ext_ptt;
  logic        ext_txinhibit;
  logic        rxgoodlvl;
  logic        rxclip;
  logic [11:0] temperature;
  logic [11:0] fwd_pwr;
  logic [11:0] rev_pwr;
  logic [11:0] bias_current;
  logic        resp_rqst;
  logic [39:0] resp;
  logic        tx_on;
  logic        pa_inttr;
  logic        pa_exttr;
  logic        pwr_envpa;
  logic        pwr_envop;
  logic        pwr_envbias;
  logic        rfsw_sel;
  logic        fan_pwm;
  logic        led_run_n;
  logic        led_tx_n;
  logic        led_rxgood_n;
  logic        led_clip_n;

  int          err_cnt;
  int          test_cnt;
  logic [31:0] rng;
  // Slot the DUT should send next
  logic [1:0]  model_slot;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  hl_ctrl_top #(
    .TICKS_PER_MS(TICKS_PER_MS), .FAN_PWM_W(FAN_PWM_W), .VERSION_MAJOR(VERSION_MAJOR)
  ) dut0 (
    .clk(clk), .slow_adc_rst(slow_adc_rst),
    .cmd_rqst_i(cmd_rqst), .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data),
    .cmd_ptt_i(cmd_ptt), .run_i(run), .ethup_i(ethup), .tx_hang_i(tx_hang),
    .cw_keydown_i(cw_keydown), .ext_ptt_i(ext_ptt), .ext_txinhibit_i(ext_txinhibit),
    .rxgoodlvl_i(rxgoodlvl), .rxclip_i(rxclip), .temperature_i(temperature),
    .fwd_pwr_i(fwd_pwr), .rev_pwr_i(rev_pwr), .bias_current_i(bias_current),
    .resp_rqst_i(resp_rqst), .resp_o(resp), .tx_on_o(tx_on),
    .pa_inttr_o(pa_inttr), .pa_exttr_o(pa_exttr), .pwr_envpa_o(pwr_envpa),
    .pwr_envop_o(pwr_envop), .pwr_envbias_o(pwr_envbias), .rfsw_sel_o(rfsw_sel),
    .fan_pwm_o(fan_pwm), .led_run_n_o(led_run_n), .led_tx_n_o(led_tx_n),
    .led_rxgood_n_o(led_rxgood_n), .led_clip_n_o(led_clip_n)
  );

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_value(input string what, input logic [39:0] got,
                             input logic [39:0] exp);
    assert (got === exp) else begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    err_cnt++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

`include "hl_ctrl_tests.svh"

  initial begin
    rng           = 32'hb3c4_d2cc;
    err_cnt       = 0;
    test_cnt      = 0;
    model_slot    = 2'd0;
    slow_adc_rst  = 1'b1;
    cmd_rqst      = 1'b0;
    cmd_addr      = '0;
    cmd_data      = '0;
    cmd_ptt       = 1'b0;
    run           = 1'b0;
    ethup         = 1'b0;
    tx_hang       = 1'b0;
    cw_keydown    = 1'b0;
    ext_ptt       = 1'b0;
    ext_txinhibit = 1'b0;
    rxgoodlvl     = 1'b0;
    rxclip        = 1'b0;
    // Cool enough to keep the fan off
    temperature   = 12'h100;
    fwd_pwr       = '0;
    rev_pwr       = '0;
    bias_current  = '0;
    resp_rqst     = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    slow_adc_rst = 1'b0;

    test_reset_state();
    test_keying();
    test_mode_cmd();
    test_fan();
    test_status_frame();
    test_clip();
    test_leds();

    $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/hl_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module hl_ctrl_top #(
  parameter int         TICKS_PER_MS  = 2500,
  parameter int         FAN_PWM_W     = 16,
  parameter logic [7:0] VERSION_MAJOR = 8'h00
) (
  input  wire                              clk,
  input  wire                              slow_adc_rst,
  input  wire                              cmd_rqst_i,
  input  wire [hl_cmd_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  wire [hl_cmd_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  wire                              cmd_ptt_i,
  input  wire                              run_i,
  input  wire                              ethup_i,
  input  wire                              tx_hang_i,
  input  wire                              cw_keydown_i,
  input  wire                              ext_ptt_i,
  input  wire                              ext_txinhibit_i,
  input  wire                              rxgoodlvl_i,
  input  wire                              rxclip_i,
  input  wire [hl_sense_pkg::SENSE_W-1:0]  temperature_i,
  input  wire [hl_sense_pkg::SENSE_W-1:0]  fwd_pwr_i,
  input  wire [hl_sense_pkg::SENSE_W-1:0]  rev_pwr_i,
  input  wire [hl_sense_pkg::SENSE_W-1:0]  bias_current_i,
  input  wire                              resp_rqst_i,
  output logic [hl_cmd_pkg::RESP_W-1:0]    resp_o,
  output logic                             tx_on_o,
  output logic                             pa_inttr_o,
  output logic                             pa_exttr_o,
  output logic                             pwr_envpa_o,
  output logic                             pwr_envop_o,
  output logic                             pwr_envbias_o,
  output logic                             rfsw_sel_o,
  output logic                             fan_pwm_o,
  output logic                             led_run_n_o,
  output logic                             led_tx_n_o,
  output logic                             led_rxgood_n_o,
  output logic                             led_clip_n_o
);

  hl_cmd_if cmd_bus ();

  hl_sense_pkg::telemetry_t telem;
  logic                     stretch_tick;
  logic                     blink;
  logic                     ptt_resp;
  logic                     temp_enabletx;

  assign cmd_bus.rqst = cmd_rqst_i;
  assign cmd_bus.addr = cmd_addr_i;
  assign cmd_bus.data = cmd_data_i;
  assign cmd_bus.ptt  = cmd_ptt_i;

  assign telem.temperature  = temperature_i;
  assign telem.fwd_pwr      = fwd_pwr_i;
  assign telem.rev_pwr      = rev_pwr_i;
  assign telem.bias_current = bias_current_i;

  ms_timebase #(.TICKS_PER_MS(TICKS_PER_MS)) timebase0 (
    .clk(clk), .slow_adc_rst(slow_adc_rst),
    .stretch_tick_o(stretch_tick), .blink_o(blink)
  );

  led_stretch rxgood_led0 (
    .clk(clk), .slow_adc_rst(slow_adc_rst),
    .trigger_i(rxgoodlvl_i), .tick_i(stretch_tick), .led_n_o(led_rxgood_n_o)
  );

  led_stretch clip_led0 (
    .clk(clk), .slow_adc_rst(slow_adc_rst),
    .trigger_i(rxclip_i), .tick_i(stretch_tick), .led_n_o(led_clip_n_o)
  );

  fan_thermal_ctrl #(.FAN_PWM_W(FAN_PWM_W)) fan0 (
    .clk(clk), .slow_adc_rst(slow_adc_rst),
    .temperature_i(telem.temperature),
    .fan_pwm_o(fan_pwm_o), .temp_enabletx_o(temp_enabletx)
  );

  tx_keying keying0 (
    .clk(clk), .slow_adc_rst(slow_adc_rst), .cmd(cmd_bus.sink),
    .cw_keydown_i(cw_keydown_i), .ext_ptt_i(ext_ptt_i),
    .ext_txinhibit_i(ext_txinhibit_i), .tx_hang_i(tx_hang_i), .run_i(run_i),
    .temp_enabletx_i(temp_enabletx), .tx_on_o(tx_on_o), .ptt_resp_o(ptt_resp),
    .pa_inttr_o(pa_inttr_o), .pa_exttr_o(pa_exttr_o), .pwr_envpa_o(pwr_envpa_o),
    .pwr_envop_o(pwr_envop_o), .pwr_envbias_o(pwr_envbias_o), .rfsw_sel_o(rfsw_sel_o)
  );

  status_frame #(.VERSION_MAJOR(VERSION_MAJOR)) frame0 (
    .clk(clk), .slow_adc_rst(slow_adc_rst), .resp_rqst_i(resp_rqst_i),
    .rxclip_i(rxclip_i), .cw_keydown_i(cw_keydown_i), .ptt_resp_i(ptt_resp),
    .telem_i(telem), .resp_o(resp_o)
  );

  // Solid when the host is running, blinking with link otherwise
  assign led_run_n_o = run_i ? 1'b0 : ~(ethup_i & blink);
  assign led_tx_n_o  = run_i ? ~tx_on_o : 1'b1;

endmodule

`default_nettype wire

//--- source/status_frame.sv
`timescale 1ns/100ps
`default_nettype none

module status_frame #(
  parameter logic [7:0] VERSION_MAJOR = 8'h00
) (
  input  wire                               clk,
  input  wire                               slow_adc_rst,
  input  wire                               resp_rqst_i,
  input  wire                               rxclip_i,
  input  wire                               cw_keydown_i,
  input  wire                               ptt_resp_i,
  input  wire hl_sense_pkg::telemetry_t     telem_i,
  output logic [hl_cmd_pkg::RESP_W-1:0]     resp_o
);

  localparam int PAY_W = hl_cmd_pkg::RESP_W - 8;

  hl_cmd_pkg::slot_t slot;
  logic [1:0]        clip_cnt;
  logic [PAY_W-1:0]  payload;

  // Payload for the slot about to be sent
  always_comb begin
    case (slot)
      2'd0:    payload = {7'h00, &clip_cnt, 16'h0000, VERSION_MAJOR};
      2'd1:    payload = {4'h0, telem_i.temperature, 4'h0, telem_i.fwd_pwr};
      2'd2:    payload = {4'h0, telem_i.rev_pwr, 4'h0, telem_i.bias_current};
      default: payload = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      slot     <= '0;
      clip_cnt <= '0;
      resp_o   <= '0;
    end else if (resp_rqst_i) begin
      resp_o   <= {3'b000, slot, cw_keydown_i, 1'b0, ptt_resp_i, payload};
      slot     <= slot + 1'b1;
      clip_cnt <= '0;
    end else if (~&clip_cnt) begin
      // Saturates at three clip cycles
      clip_cnt <= clip_cnt + {1'b0, rxclip_i};
    end
  end

  a_slot_rotates: assert property (
    @(posedge clk) disable iff (slow_adc_rst)
    resp_rqst_i |=> (slot == hl_cmd_pkg::slot_t'($past(slot) + 1'b1))
  );

endmodule

`default_nettype wire

//--- source/tx_keying.sv
`timescale 1ns/100ps
`default_nettype none

module tx_keying (
  input  wire      clk,
  input  wire      slow_adc_rst,
  hl_cmd_if.sink   cmd,
  input  wire      cw_keydown_i,
  input  wire      ext_ptt_i,
  input  wire      ext_txinhibit_i,
  input  wire      tx_hang_i,
  input  wire      run_i,
  input  wire      temp_enabletx_i,
  output logic     tx_on_o,
  output logic     ptt_resp_o,
  output logic     pa_inttr_o,
  output logic     pa_exttr_o,
  output logic     pwr_envpa_o,
  output logic     pwr_envop_o,
  output logic     pwr_envbias_o,
  output logic     rfsw_sel_o
);

  logic vna;
  logic pa_enable;
  logic tr_disable;
  logic int_ptt;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      vna        <= 1'b0;
      pa_enable  <= 1'b0;
      tr_disable <= 1'b0;
      int_ptt    <= 1'b0;
      tx_on_o    <= 1'b0;
      ptt_resp_o <= 1'b0;
    end else begin
      // PTT rides along with every command
      if (cmd.rqst) begin
        int_ptt <= cmd.ptt;
        if (cmd.addr == hl_cmd_pkg::CMD_ADDR_MODE) begin
          vna        <= cmd.data[hl_cmd_pkg::MODE_BIT_VNA];
          pa_enable  <= cmd.data[hl_cmd_pkg::MODE_BIT_PA_EN];
          tr_disable <= cmd.data[hl_cmd_pkg::MODE_BIT_TR_DIS];
        end
      end
      tx_on_o <= (int_ptt | cw_keydown_i | ext_ptt_i | tx_hang_i) &
                 ~ext_txinhibit_i & run_i & temp_enabletx_i;
      // Hang time is not reported back to the host
      ptt_resp_o <= cw_keydown_i | ext_ptt_i;
    end
  end

  // PA path and supply enables
  assign pwr_envbias_o = tx_on_o & ~vna & pa_enable;
  assign pwr_envop_o   = tx_on_o;
  assign pa_exttr_o    = tx_on_o;
  assign pa_inttr_o    = tx_on_o & ~vna & (pa_enable | ~tr_disable);
  assign pwr_envpa_o   = tx_on_o & ~vna & pa_enable;
  assign rfsw_sel_o    = ~vna & pa_enable;

  // PA supply only follows a cycle where keying was permitted
  a_envpa_keyed: assert property (
    @(posedge clk) disable iff (slow_adc_rst)
    pwr_envpa_o |-> tx_on_o && $past(run_i && temp_enabletx_i && !ext_txinhibit_i)
  );

endmodule

`default_nettype wire

//--- source/fan_thermal_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module fan_thermal_ctrl #(
  parameter int FAN_PWM_W = 16
) (
  input  wire                             clk,
  input  wire                             slow_adc_rst,
  input  wire [hl_sense_pkg::SENSE_W-1:0] temperature_i,
  output logic                            fan_pwm_o,
  output logic                            temp_enabletx_o
);

  hl_sense_pkg::fan_state_t state;
  hl_sense_pkg::fan_state_t state_next;
  logic [FAN_PWM_W-1:0]     pwm_cnt;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      state   <= hl_sense_pkg::FAN_OFF;
      pwm_cnt <= '0;
    end else begin
      state   <= state_next;
      pwm_cnt <= pwm_cnt + 1'b1;
    end
  end

  // Each step up and down uses a 5C gap for hysteresis
  always_comb begin
    state_next      = state;
    fan_pwm_o       = 1'b0;
    temp_enabletx_o = 1'b1;
    case (state)
      hl_sense_pkg::FAN_OFF: begin
        if (temperature_i > hl_sense_pkg::TEMP_35C) state_next = hl_sense_pkg::FAN_LOW;
      end
      hl_sense_pkg::FAN_LOW: begin
        if (temperature_i > hl_sense_pkg::TEMP_40C) state_next = hl_sense_pkg::FAN_MED;
        else if (temperature_i < hl_sense_pkg::TEMP_30C) state_next = hl_sense_pkg::FAN_OFF;
        // 50% duty
        fan_pwm_o = pwm_cnt[FAN_PWM_W-1];
      end
      hl_sense_pkg::FAN_MED: begin
        if (temperature_i > hl_sense_pkg::TEMP_45C) state_next = hl_sense_pkg::FAN_FULL;
        else if (temperature_i < hl_sense_pkg::TEMP_35C) state_next = hl_sense_pkg::FAN_LOW;
        // 75% duty
        fan_pwm_o = pwm_cnt[FAN_PWM_W-1] | pwm_cnt[FAN_PWM_W-2];
      end
      hl_sense_pkg::FAN_FULL: begin
        if (temperature_i > hl_sense_pkg::TEMP_55C) state_next = hl_sense_pkg::FAN_OVERHEAT;
        else if (temperature_i < hl_sense_pkg::TEMP_40C) state_next = hl_sense_pkg::FAN_MED;
        fan_pwm_o = 1'b1;
      end
      hl_sense_pkg::FAN_OVERHEAT: begin
        if (temperature_i < hl_sense_pkg::TEMP_50C) state_next = hl_sense_pkg::FAN_FULL;
        // Full fan and no transmit until it cools
        fan_pwm_o       = 1'b1;
        temp_enabletx_o = 1'b0;
      end
      default: begin
        state_next = hl_sense_pkg::FAN_OFF;
      end
    endcase
  end

  // TX cutoff only in overheat, which is entered from full speed alone
  a_cutoff_overheat: assert property (
    @(posedge clk) disable iff (slow_adc_rst)
    !temp_enabletx_o |-> (state == hl_sense_pkg::FAN_OVERHEAT) &&
      ($past(state) inside {hl_sense_pkg::FAN_FULL, hl_sense_pkg::FAN_OVERHEAT})
  );

endmodule

`default_nettype wire

//--- source/led_stretch.sv
`timescale 1ns/100ps
`default_nettype none

module led_stretch (
  input  wire  clk,
  input  wire  slow_adc_rst,
  input  wire  trigger_i,
  input  wire  tick_i,
  output logic led_n_o
);

  typedef enum logic [1:0] {
    ST_IDLE  = 2'b00,
    ST_SET   = 2'b01,
    ST_WAIT1 = 2'b10,
    ST_WAIT2 = 2'b11
  } state_t;

  state_t state;

  // LED stays lit for two to three ticks
  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:  if (trigger_i) state <= ST_SET;
        ST_SET:   if (tick_i) state <= ST_WAIT1;
        ST_WAIT1: if (tick_i) state <= ST_WAIT2;
        ST_WAIT2: if (tick_i) state <= ST_IDLE;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  // Active low pin
  assign led_n_o = (state == ST_IDLE);

  // LED goes dark only on a stretch tick
  a_dark_on_tick: assert property (
    @(posedge clk) disable iff (slow_adc_rst)
    $rose(led_n_o) |-> $past(tick_i)
  );

endmodule

`default_nettype wire

//--- source/ms_timebase.sv
`timescale 1ns/100ps
`default_nettype none

module ms_timebase #(
  parameter int TICKS_PER_MS = 2500
) (
  input  wire  clk,
  input  wire  slow_adc_rst,
  output logic stretch_tick_o,
  output logic blink_o
);

  localparam int CYC_W = (TICKS_PER_MS > 1) ? $clog2(TICKS_PER_MS) : 1;
  localparam int MS_W  = hl_sense_pkg::BLINK_MS_LOG2 + 1;

  logic [CYC_W-1:0] cyc_cnt;
  logic [MS_W-1:0]  ms_cnt;
  logic             ms_wrap;

  // Last clk cycle of each millisecond
  assign ms_wrap = (cyc_cnt == CYC_W'(TICKS_PER_MS - 1));

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      cyc_cnt        <= '0;
      ms_cnt         <= '0;
      stretch_tick_o <= 1'b0;
    end else begin
      // Single-cycle pulse as the low millisecond bits roll over
      stretch_tick_o <= ms_wrap & (&ms_cnt[hl_sense_pkg::STRETCH_MS_LOG2-1:0]);
      if (ms_wrap) begin
        cyc_cnt <= '0;
        ms_cnt  <= ms_cnt + 1'b1;
      end else begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

  assign blink_o = ms_cnt[hl_sense_pkg::BLINK_MS_LOG2];

endmodule

`default_nettype wire

//--- source/hl_cmd_if.sv
`timescale 1ns/100ps
`default_nettype none

// Host command strobe with its address, data and PTT
interface hl_cmd_if;

  logic                              rqst;
  logic [hl_cmd_pkg::CMD_ADDR_W-1:0] addr;
  logic [hl_cmd_pkg::CMD_DATA_W-1:0] data;
  logic                              ptt;

  // Driven by the top level from its input ports
  modport source (output rqst, output addr, output data, output ptt);

  // Keying and mode decode
  modport sink (input rqst, input addr, input data, input ptt);

endinterface

`default_nettype wire

//--- source/hl_sense_pkg.sv
`default_nettype none

// Telemetry, thermal and timebase definitions
package hl_sense_pkg;

  // Slow ADC sample width
  localparam int SENSE_W = 12;

  typedef struct packed {
    logic [SENSE_W-1:0] temperature;
    logic [SENSE_W-1:0] fwd_pwr;
    logic [SENSE_W-1:0] rev_pwr;
    logic [SENSE_W-1:0] bias_current;
  } telemetry_t;

  // Code = (((T * 0.01) + 0.5) / 3.26) * 4096
  localparam logic [SENSE_W-1:0] TEMP_30C = 12'b001111101101;
  localparam logic [SENSE_W-1:0] TEMP_35C = 12'b010000101011;
  localparam logic [SENSE_W-1:0] TEMP_40C = 12'b010001101011;
  localparam logic [SENSE_W-1:0] TEMP_45C = 12'b010010101010;
  localparam logic [SENSE_W-1:0] TEMP_50C = 12'b010011101000;
  localparam logic [SENSE_W-1:0] TEMP_55C = 12'b010100100111;

  // Gray-like encoding, one bit flips per step
  typedef enum logic [2:0] {
    FAN_OFF      = 3'b000,
    FAN_LOW      = 3'b001,
    FAN_MED      = 3'b011,
    FAN_FULL     = 3'b010,
    FAN_OVERHEAT = 3'b110
  } fan_state_t;

  // LED stretch tick every 64 ms
  localparam int STRETCH_MS_LOG2 = 6;

  // Blink level toggles every 256 ms
  localparam int BLINK_MS_LOG2 = 8;

endpackage

`default_nettype wire

//--- source/hl_cmd_pkg.sv
`default_nettype none

// Host command and status-frame definitions
package hl_cmd_pkg;

  // Command bus widths
  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;

  // Mode command and its field positions
  localparam logic [CMD_ADDR_W-1:0] CMD_ADDR_MODE = 6'h09;

  // Selects VNA mode
  localparam int MODE_BIT_VNA    = 23;
  localparam int MODE_BIT_PA_EN  = 19;
  localparam int MODE_BIT_TR_DIS = 18;

  // Status frame returned to the host
  localparam int RESP_W = 40;

  // Four rotating slots
  typedef logic [1:0] slot_t;

endpackage

`default_nettype wire
